//--- hdl/rle_pkg.sv
package rle_pkg;

//////////////////////////////////////////////////
// widths and depths
//////////////////////////////////////////////////

localparam int unsigned DW         = 8;   // sample width
localparam int unsigned CW         = 8;   // run count width
localparam int unsigned FIFO_DEPTH = 4;   // output buffer, run words
localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);  // buffer pointer width
localparam int unsigned STAT_W     = 16;  // statistics counter width

//////////////////////////////////////////////////
// stream payloads
//////////////////////////////////////////////////

// one input sample
typedef struct packed {
  logic signed [DW-1:0] data;
  logic                 last;  // final sample of packet
} sample_t;

// one output run word
typedef struct packed {
  logic signed [DW-1:0] data;   // repeated value
  logic        [CW-1:0] count;  // run length minus one
  logic                 last;   // word closes the packet
} run_t;

//////////////////////////////////////////////////
// encoder state
//////////////////////////////////////////////////

typedef enum logic {
  EMPTY = 1'b0,  // nothing held
  HOLD  = 1'b1   // run being counted
} enc_state_e;

endpackage: rle_pkg

//--- hdl/rle_encoder.sv
`timescale 1ns/1ps

module rle_encoder (
  input  logic             sti,
  input  logic             rst_n,
  // configuration
  input  logic             cfg_ena,   // 0 = pass samples through
  input  logic             ctl_rst,   // drop held run
  // sample stream
  input  logic             in_valid,
  output logic             in_ready,
  input  rle_pkg::sample_t in_sample,
  // run word stream
  output logic             enc_valid,
  input  logic             enc_ready,
  output rle_pkg::run_t    enc_run
);

//////////////////////////////////////////////////
// held run
//////////////////////////////////////////////////

rle_pkg::enc_state_e            state, state_nxt;
logic signed [rle_pkg::DW-1:0]  run_data, run_data_nxt;  // value of held run
logic        [rle_pkg::CW-1:0]  run_cnt, run_cnt_nxt;    // length minus one
logic                           run_last, run_last_nxt;  // held run ends packet
logic                           pend, pend_nxt;          // held run must go out next

logic                           out_free;  // output register can take a word
logic                           in_fire;
logic                           held;      // run present and not being dropped
logic                           same;      // sample extends held run
logic        [rle_pkg::CW-1:0]  cnt_inc;
logic                           emit;      // load output register
rle_pkg::run_t                  emit_run;

assign out_free = ~enc_valid | enc_ready;
assign in_ready = out_free & ~pend;  // stall while a pending run drains
assign in_fire  = in_valid & in_ready;

assign held    = (state == rle_pkg::HOLD) & ~ctl_rst;
assign same    = (in_sample.data == run_data);
assign cnt_inc = run_cnt + 1'b1;

//////////////////////////////////////////////////
// run detection
//////////////////////////////////////////////////

always_comb begin
  state_nxt      = state;
  run_data_nxt   = run_data;
  run_cnt_nxt    = run_cnt;
  run_last_nxt   = run_last;
  pend_nxt       = pend;
  emit           = 1'b0;
  emit_run.data  = run_data;
  emit_run.count = run_cnt;
  emit_run.last  = run_last;
  if (ctl_rst) begin
    state_nxt = rle_pkg::EMPTY;  // discard whatever is being built
    pend_nxt  = 1'b0;
  end
  if (pend & ~ctl_rst) begin
    // flush the run opened by a closing sample
    if (out_free) begin
      emit      = 1'b1;
      state_nxt = rle_pkg::EMPTY;
      pend_nxt  = 1'b0;
    end
  end else if (in_fire) begin
    if (held & same) begin
      // grow the run, close on last, saturation or bypass
      emit_run.count = cnt_inc;
      emit_run.last  = in_sample.last;
      if (in_sample.last | (&cnt_inc) | ~cfg_ena) begin
        emit      = 1'b1;
        state_nxt = rle_pkg::EMPTY;
      end else begin
        run_cnt_nxt = cnt_inc;
      end
    end else if (held) begin
      // value changed, old run out, new one opens
      emit          = 1'b1;
      emit_run.last = 1'b0;
      run_data_nxt  = in_sample.data;
      run_cnt_nxt   = '0;
      run_last_nxt  = in_sample.last;
      state_nxt     = rle_pkg::HOLD;
      pend_nxt      = in_sample.last | ~cfg_ena;  // cannot wait for more samples
    end else if (in_sample.last | ~cfg_ena) begin
      // single sample word
      emit           = 1'b1;
      emit_run.data  = in_sample.data;
      emit_run.count = '0;
      emit_run.last  = in_sample.last;
      state_nxt      = rle_pkg::EMPTY;
    end else begin
      run_data_nxt = in_sample.data;  // start counting
      run_cnt_nxt  = '0;
      run_last_nxt = 1'b0;
      state_nxt    = rle_pkg::HOLD;
    end
  end
end

//////////////////////////////////////////////////
// registers
//////////////////////////////////////////////////

always_ff @(posedge sti or negedge rst_n) begin
  if (!rst_n) begin
    state     <= rle_pkg::EMPTY;
    pend      <= 1'b0;
    enc_valid <= 1'b0;
  end else begin
    state <= state_nxt;
    pend  <= pend_nxt;
    if (out_free) enc_valid <= emit;  // ctl_rst leaves this alone
  end
end

always_ff @(posedge sti) begin
  run_data <= run_data_nxt;
  run_cnt  <= run_cnt_nxt;
  run_last <= run_last_nxt;
  if (emit) enc_run <= emit_run;
end

endmodule: rle_encoder

//--- hdl/rle_fifo.sv
`timescale 1ns/1ps

module rle_fifo (
  input  logic          sti,
  input  logic          rst_n,
  // write side, from encoder
  input  logic          wr_valid,
  output logic          wr_ready,
  input  rle_pkg::run_t wr_run,
  // read side, to sink
  output logic          rd_valid,
  input  logic          rd_ready,
  output rle_pkg::run_t rd_run
);

//////////////////////////////////////////////////
// storage and pointers
//////////////////////////////////////////////////

rle_pkg::run_t                 mem [rle_pkg::FIFO_DEPTH];  // flop array
logic [rle_pkg::FIFO_AW-1:0]   wr_ptr;
logic [rle_pkg::FIFO_AW-1:0]   rd_ptr;
logic [rle_pkg::FIFO_AW:0]     fill;    // words stored, 0..FIFO_DEPTH

logic wr_fire;
logic rd_fire;

assign wr_ready = (fill != rle_pkg::FIFO_DEPTH[rle_pkg::FIFO_AW:0]);  // low only when full
assign rd_valid = (fill != '0);
assign rd_run   = mem[rd_ptr];  // straight from storage flops

assign wr_fire = wr_valid & wr_ready;
assign rd_fire = rd_valid & rd_ready;

//////////////////////////////////////////////////
// control
//////////////////////////////////////////////////

// depth is a power of two so pointers wrap by overflow
always_ff @(posedge sti or negedge rst_n) begin
  if (!rst_n) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
    fill   <= '0;
  end else begin
    if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
    if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
    case ({wr_fire, rd_fire})
      2'b10:   fill <= fill + 1'b1;
      2'b01:   fill <= fill - 1'b1;
      default: fill <= fill;  // both or neither
    endcase
  end
end

// payload write
always_ff @(posedge sti) begin
  if (wr_fire) mem[wr_ptr] <= wr_run;
end

endmodule: rle_fifo

//--- hdl/rle_stats.sv
`timescale 1ns/1ps

module rle_stats (
  input  logic                       sti,
  input  logic                       rst_n,
  // observed transfers
  input  logic                       in_fire,   // sample accepted
  input  logic                       out_fire,  // run word delivered
  input  logic                       out_last,  // delivered word ends packet
  // per packet totals
  output logic                       stat_valid,
  output logic [rle_pkg::STAT_W-1:0] stat_samples,
  output logic [rle_pkg::STAT_W-1:0] stat_words
);

logic [rle_pkg::STAT_W-1:0] in_cnt;   // running sample count
logic [rle_pkg::STAT_W-1:0] out_cnt;  // running word count
logic                       pkt_end;

assign pkt_end = out_fire & out_last;

//////////////////////////////////////////////////
// counters aligned to output packet ends
//////////////////////////////////////////////////

always_ff @(posedge sti or negedge rst_n) begin
  if (!rst_n) begin
    in_cnt       <= '0;
    out_cnt      <= '0;
    stat_valid   <= 1'b0;
    stat_samples <= '0;
    stat_words   <= '0;
  end else begin
    stat_valid <= pkt_end;  // one cycle pulse
    if (pkt_end) begin
      stat_samples <= in_cnt;
      stat_words   <= out_cnt + 1'b1;  // include this word
      in_cnt       <= {{(rle_pkg::STAT_W-1){1'b0}}, in_fire};  // sample now belongs to next packet
      out_cnt      <= '0;
    end else begin
      if (in_fire)  in_cnt  <= in_cnt + 1'b1;
      if (out_fire) out_cnt <= out_cnt + 1'b1;
    end
  end
end

endmodule: rle_stats

//--- hdl/rle_top.sv
`timescale 1ns/1ps

module rle_top (
  input  logic                       sti,
  input  logic                       rst_n,
  // configuration
  input  logic                       cfg_ena,
  input  logic                       ctl_rst,
  // sample stream in
  input  logic                       in_valid,
  output logic                       in_ready,
  input  rle_pkg::sample_t           in_sample,
  // run word stream out
  output logic                       out_valid,
  input  logic                       out_ready,
  output rle_pkg::run_t              out_run,
  // statistics
  output logic                       stat_valid,
  output logic [rle_pkg::STAT_W-1:0] stat_samples,
  output logic [rle_pkg::STAT_W-1:0] stat_words
);

//////////////////////////////////////////////////
// encoder to buffer
//////////////////////////////////////////////////

logic          enc_valid;
logic          enc_ready;
rle_pkg::run_t enc_run;

logic in_fire;   // top level sample transfer
logic out_fire;  // top level word transfer

assign in_fire  = in_valid & in_ready;
assign out_fire = out_valid & out_ready;

rle_encoder u_enc (
  .sti       (sti),
  .rst_n     (rst_n),
  .cfg_ena   (cfg_ena),
  .ctl_rst   (ctl_rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_sample (in_sample),
  .enc_valid (enc_valid),
  .enc_ready (enc_ready),
  .enc_run   (enc_run)
);

rle_fifo u_fifo (
  .sti      (sti),
  .rst_n    (rst_n),
  .wr_valid (enc_valid),
  .wr_ready (enc_ready),
  .wr_run   (enc_run),
  .rd_valid (out_valid),
  .rd_ready (out_ready),
  .rd_run   (out_run)
);

//////////////////////////////////////////////////
// packet statistics
//////////////////////////////////////////////////

rle_stats u_stats (
  .sti          (sti),
  .rst_n        (rst_n),
  .in_fire      (in_fire),
  .out_fire     (out_fire),
  .out_last     (out_run.last),  // packet end seen at output
  .stat_valid   (stat_valid),
  .stat_samples (stat_samples),
  .stat_words   (stat_words)
);

endmodule: rle_top

//--- bench/rle_clkgen.sv
`timescale 1ns/1ps

module rle_clkgen (
  output logic sti,
  output logic rst_n
);

localparam int HALF_NS    = 2;  // 4 ns period
localparam int RST_CYCLES = 5;

initial begin
  sti = 1'b0;
  forever #(HALF_NS) sti = ~sti;
end

initial begin
  rst_n = 1'b0;
  repeat (RST_CYCLES) @(posedge sti);
  #1 rst_n = 1'b1;  // release off the edge, like the stimulus
end

endmodule: rle_clkgen

//--- bench/rle_chk.sv
`timescale 1ns/1ps

module rle_chk (
  input logic             sti,
  input logic             rst_n,
  input logic             in_valid,
  input logic             in_ready,
  input rle_pkg::sample_t in_sample,
  input logic             out_valid,
  input logic             out_ready,
  input rle_pkg::run_t    out_run
);

int unsigned fail_cnt = 0;  // failed assertions so far

//////////////////////////////////////////////////
// handshake rules
//////////////////////////////////////////////////

// stalled word must not change under the sink
a_out_hold: assert property (@(posedge sti) disable iff (!rst_n)
  out_valid && !out_ready |=> $stable(out_run))
  else begin
    fail_cnt++;
    $error("out_run changed while out_valid waited for out_ready");
  end

// source side, same rule
a_in_hold: assert property (@(posedge sti) disable iff (!rst_n)
  in_valid && !in_ready |=> $stable(in_sample))
  else begin
    fail_cnt++;
    $error("in_sample changed while in_valid waited for in_ready");
  end

a_reset_idle: assert property (@(posedge sti) $rose(rst_n) |-> !out_valid)
  else begin
    fail_cnt++;
    $error("out_valid high right after reset release");
  end

endmodule: rle_chk

bind rle_top rle_chk u_chk (
  .sti       (sti),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_sample (in_sample),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_run   (out_run)
);

//--- bench/rle_tb.sv
`timescale 1ns/1ps

module rle_tb;

localparam int MAX_REC = 64;  // pattern memory slots

logic                       sti, rst_n;
logic                       cfg_ena, ctl_rst;
logic                       in_valid, in_ready, out_valid, out_ready;
rle_pkg::sample_t           in_sample;
rle_pkg::run_t              out_run;
logic                       stat_valid;
logic [rle_pkg::STAT_W-1:0] stat_samples, stat_words;

logic [39:0]   pat_mem [MAX_REC];  // tag | flags | field a | field b
logic [39:0]   in_recs [$];
rle_pkg::run_t exp_words [$];
logic [31:0]   exp_stats [$];      // samples | words

int     n_words, n_stats, n_samples, word_idx, stat_idx, pkts_sent;
int     err_words, err_stats, err_other, cycle_cnt, cycle_limit;
integer seed = 32'he001;

rle_clkgen u_clkgen (.sti(sti), .rst_n(rst_n));

rle_top dut (
  .sti          (sti),
  .rst_n        (rst_n),
  .cfg_ena      (cfg_ena),
  .ctl_rst      (ctl_rst),
  .in_valid     (in_valid),
  .in_ready     (in_ready),
  .in_sample    (in_sample),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_run      (out_run),
  .stat_valid   (stat_valid),
  .stat_samples (stat_samples),
  .stat_words   (stat_words)
);

//////////////////////////////////////////////////
// pattern loading
//////////////////////////////////////////////////

task automatic load_patterns();
  rle_pkg::run_t w;
  int            i;
  for (i = 0; i < MAX_REC; i++)
    pat_mem[i] = '0;  // tag 0 marks an unused slot
  $readmemh("bench/rle_patterns.txt", pat_mem);
  for (i = 0; i < MAX_REC; i++) begin
    case (pat_mem[i][39:36])
      4'h1: begin
        in_recs.push_back(pat_mem[i]);
        if (!pat_mem[i][33])
          n_samples += int'(pat_mem[i][31:16]);  // ctl_rst records carry none
      end
      4'h2: begin
        w.data  = pat_mem[i][7:0];
        w.count = pat_mem[i][15:8];
        w.last  = pat_mem[i][32];
        exp_words.push_back(w);
      end
      4'h3: exp_stats.push_back(pat_mem[i][31:0]);
      default: ;
    endcase
  end
  n_words = exp_words.size();
  n_stats = exp_stats.size();
  assert (in_recs.size() > 0 && n_words > 0) else begin
    err_other++;
    $display("no usable records found in bench/rle_patterns.txt");
  end
endtask

//////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////

task automatic send_sample(input logic ena, input logic last, input logic [7:0] data);
  cfg_ena        = ena;
  in_valid       = 1'b1;
  in_sample.data = data;
  in_sample.last = last;
  @(negedge sti);
  while (!in_ready)
    @(negedge sti);
  @(posedge sti);  // transfer edge
  #1;
  in_valid = 1'b0;
endtask

task automatic pulse_ctl_rst(input logic ena);
  cfg_ena = ena;
  ctl_rst = 1'b1;
  @(posedge sti);
  #1;
  ctl_rst = 1'b0;
endtask

task automatic play_record(input logic [39:0] rec);
  int k;
  int reps;
  reps = int'(rec[31:16]);
  if (rec[33]) begin
    pulse_ctl_rst(rec[32]);
  end else begin
    for (k = 0; k < reps; k++)
      send_sample(rec[32], rec[34] && (k == reps - 1), rec[7:0]);
  end
  if (rec[34]) begin
    pkts_sent++;
    wait (stat_idx >= pkts_sent);  // totals in before next packet
    @(posedge sti);
    #1;
  end
endtask

// random sink ready about 3 of 4 cycles
initial begin
  out_ready = 1'b0;
  wait (rst_n);
  forever begin
    @(posedge sti);
    #1;
    out_ready = ($random(seed) & 3) != 0;
  end
end

//////////////////////////////////////////////////
// checking
//////////////////////////////////////////////////

task automatic report_mismatch(input string sig, input int exp_v, input int act_v);
  $display("** Error at %0t ns: %s expected %0d, got %0d", $time, sig, exp_v, act_v);
endtask

task automatic check_word();
  rle_pkg::run_t exp;
  assert (word_idx < n_words) else begin
    err_other++;
    $display("extra run word at %0t ns after all expected words", $time);
  end
  if (word_idx < n_words) begin
    exp = exp_words[word_idx];
    assert (out_run.data == exp.data) else begin
      err_words++;
      report_mismatch("out_run.data", int'(exp.data), int'(out_run.data));
    end
    assert (out_run.count == exp.count) else begin
      err_words++;
      report_mismatch("out_run.count", int'(exp.count), int'(out_run.count));
    end
    assert (out_run.last == exp.last) else begin
      err_words++;
      report_mismatch("out_run.last", int'(exp.last), int'(out_run.last));
    end
  end
  word_idx++;
endtask

task automatic check_stats();
  logic [31:0] exp;
  assert (stat_idx < n_stats) else begin
    err_other++;
    $display("stat_valid pulse at %0t ns with no packet left to match", $time);
  end
  if (stat_idx < n_stats) begin
    exp = exp_stats[stat_idx];
    assert (stat_samples == exp[31:16]) else begin
      err_stats++;
      report_mismatch("stat_samples", int'(exp[31:16]), int'(stat_samples));
    end
    assert (stat_words == exp[15:0]) else begin
      err_stats++;
      report_mismatch("stat_words", int'(exp[15:0]), int'(stat_words));
    end
  end
  stat_idx++;
endtask

// sampled at negedge where both sides are settled
always @(negedge sti) begin
  if (rst_n && out_valid && out_ready)
    check_word();
  if (rst_n && stat_valid)
    check_stats();
end

task automatic finish_run();
  int chk_fails;
  chk_fails = int'(dut.u_chk.fail_cnt);
  $display("errors: words %0d, stats %0d, other %0d, assertions %0d",
           err_words, err_stats, err_other, chk_fails);
  if (err_words + err_stats + err_other + chk_fails == 0) begin
    $display("Simulation completed successfully");
  end else begin
    $display("Simulation failed");
  end
  $finish;
endtask

//////////////////////////////////////////////////
// main flow and timeout
//////////////////////////////////////////////////

initial begin
  cfg_ena   = 1'b1;
  ctl_rst   = 1'b0;
  in_valid  = 1'b0;
  in_sample = '0;
  load_patterns();
  cycle_limit = 8 * n_samples + 200;
  wait (rst_n);
  @(posedge sti);
  #1;
  // encoder idle after reset takes samples at once
  assert (in_ready === 1'b1) else begin
    err_other++;
    report_mismatch("in_ready", 1, int'(in_ready));
  end
  foreach (in_recs[i])
    play_record(in_recs[i]);
  wait (word_idx >= n_words && stat_idx >= n_stats);
  repeat (20) @(posedge sti);  // room for stray words
  finish_run();
end

initial begin
  wait (cycle_limit > 0);
  while (cycle_cnt < cycle_limit) begin
    @(posedge sti);
    cycle_cnt++;
  end
  err_other++;
  $display("timeout after %0d cycles, reached before all words arrived", cycle_cnt);
  finish_run();
end

endmodule: rle_tb

//--- bench/rle_patterns.txt
// tag 1 sample: flags (1 cfg_ena, 2 ctl_rst, 4 last) | repeat | 00 | data
// tag 2 word: last | 0000 | count | data     tag 3 stats: 0 | samples | words
// packet 1, mixed runs, last on an equal sample
1100030005
110001007F
1100020080
1500020005
2000000205
200000007F
2000000180
2100000105
3000080004
// packet 2, 300 equal samples split at saturation
15012C00C4
200000FFC4
2100002BC4
30012C0002
// packet 3, pass-through, equal neighbors stay apart
1000020011
1400020022
2000000011
2000000011
2000000022
2100000022
3000040004
// packet 4, ctl_rst drops the held 42 run, its samples still counted
1100010009
1100040042
1300000000
1100020042
1500010009
2000000009
2000000142
2100000009
3000080003

//--- rle_top.f
hdl/rle_pkg.sv
hdl/rle_encoder.sv
hdl/rle_fifo.sv
hdl/rle_stats.sv
hdl/rle_top.sv
bench/rle_clkgen.sv
bench/rle_chk.sv
bench/rle_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rle_tb
FLIST     ?= rle_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
